// ==== build.f ====
+incdir+common
common/lockin_pkg.sv
common/frame_if.sv
rtl/pem_frame_seq.sv
lockin_accum/lockin_mixer.sv
lockin_accum/frame_accum.sv
rtl/lockin_top.sv
verif/lockin_chk.sv
verif/lockin_scoreboard.sv
verif/lockin_tb.sv

// ==== common/frame_if.sv ====
`timescale 1ns/10ps
`default_nettype none

// sequencer to demodulator, all single cycle qualified
interface frame_if;

  import lockin_pkg::*;

  logic    sample_stb;  // table request issued this cycle
  logic    frame_end;   // frame boundary cycle
  logic    bank;        // bank of the frame in progress
  sample_t ref_sample;  // sample paired with the request

  modport seq (
    output sample_stb,
    output frame_end,
    output bank,
    output ref_sample
  );

  modport demod (
    input  sample_stb,
    input  frame_end,
    input  bank,
    input  ref_sample
  );

endinterface

`default_nettype wire

// ==== common/lockin_config.svh ====
`ifndef LOCKIN_CONFIG_SVH
`define LOCKIN_CONFIG_SVH

////////////////////////////////////////////////////////////
// frame geometry
////////////////////////////////////////////////////////////

`define LOCKIN_FRAME_PERIODS 5   // pem periods per frame
`define LOCKIN_CNT_W         3   // period counter width

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

`define LOCKIN_SAMPLE_W      16  // reference sample, signed
`define LOCKIN_WAVE_W        16  // sign, 1 int, 14 frac
`define LOCKIN_PROD_W        32  // sample x wave
`define LOCKIN_ACC_W         40  // frame sum, headroom for long frames
`define LOCKIN_ADDR_W        9   // 512 entry wave table

// boundary to sum strobe, mixer 2 + accum 1
`define LOCKIN_SUM_LAT       3

`endif

// ==== common/lockin_pkg.sv ====
`default_nettype none

package lockin_pkg;

  `include "lockin_config.svh"

  ////////////////////////////////////////////////////////////
  // datapath types
  ////////////////////////////////////////////////////////////

  typedef logic signed [`LOCKIN_SAMPLE_W-1:0] sample_t; // reference sample
  typedef logic signed [`LOCKIN_WAVE_W-1:0]   wave_t;   // sine/cosine table value
  typedef logic signed [`LOCKIN_PROD_W-1:0]   prod_t;   // mixer product
  typedef logic signed [`LOCKIN_ACC_W-1:0]    acc_t;    // frame sum

  typedef logic [`LOCKIN_ADDR_W-1:0] wave_addr_t;       // table index, wraps
  typedef logic [`LOCKIN_CNT_W-1:0]  period_cnt_t;      // pem period in frame

  ////////////////////////////////////////////////////////////
  // sequencer FSM
  ////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    SEQ_IDLE   = 2'd0,  // waiting for search_end
    SEQ_ARMED  = 2'd1,  // waiting for first pem edge
    SEQ_SYNCED = 2'd2   // locked, frames running
  } seq_state_t;

endpackage

`default_nettype wire

// ==== lockin_accum/frame_accum.sv ====
`timescale 1ns/10ps
`default_nettype none

module frame_accum (
  input  wire                    alg_clk,
  input  wire                    alg_rst_n,
  input  wire                    prod_valid,
  input  wire lockin_pkg::prod_t prod_i,
  input  wire lockin_pkg::prod_t prod_q,
  input  wire                    prod_bank,       // target bank of this product
  input  wire                    prod_frame_end,  // drain request
  input  wire                    prod_end_bank,   // bank to drain
  output lockin_pkg::acc_t       i_sum,           // in-phase frame sum
  output lockin_pkg::acc_t       q_sum,           // quadrature frame sum
  output logic                   sum_valid        // one cycle per frame
);

  import lockin_pkg::*;

  acc_t acc_i [2];   // ping/pong in-phase
  acc_t acc_q [2];   // ping/pong quadrature
  acc_t nxt_i [2];   // bank value with this cycle's product
  acc_t nxt_q [2];
  acc_t add_i;
  acc_t add_q;

  ////////////////////////////////////////////////////////////
  // bank update
  ////////////////////////////////////////////////////////////

  assign add_i = acc_t'(prod_i);   // sign extend to sum width
  assign add_q = acc_t'(prod_q);

  always_comb
  begin
    for (int b = 0; b < 2; b++)
    begin
      nxt_i[b] = acc_i[b];
      nxt_q[b] = acc_q[b];
      if (prod_valid && (prod_bank == 1'(b)))
      begin
        nxt_i[b] = acc_i[b] + add_i;
        nxt_q[b] = acc_q[b] + add_q;
      end
    end
  end

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      for (int b = 0; b < 2; b++)
      begin
        acc_i[b] <= '0;
        acc_q[b] <= '0;
      end
    end
    else
    begin
      for (int b = 0; b < 2; b++)
      begin
        if (prod_frame_end && (prod_end_bank == 1'(b)))
        begin
          acc_i[b] <= '0;       // drained, ready for the frame after next
          acc_q[b] <= '0;
        end
        else
        begin
          acc_i[b] <= nxt_i[b];
          acc_q[b] <= nxt_q[b];
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // frame sum output
  ////////////////////////////////////////////////////////////

  always_ff @(posedge alg_clk)
  begin
    if (prod_frame_end)
    begin
      // includes a same cycle product for the closing bank
      i_sum <= prod_end_bank ? nxt_i[1] : nxt_i[0];
      q_sum <= prod_end_bank ? nxt_q[1] : nxt_q[0];
    end
  end

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
      sum_valid <= 1'b0;
    else
      sum_valid <= prod_frame_end;   // third cycle after buf_refresh
  end

endmodule

`default_nettype wire

// ==== lockin_accum/lockin_mixer.sv ====
`timescale 1ns/10ps
`default_nettype none

module lockin_mixer (
  input  wire                 alg_clk,
  input  wire                 alg_rst_n,
  frame_if.demod              frm,
  input  wire lockin_pkg::wave_t wave_sine,   // arrives one cycle after request
  input  wire lockin_pkg::wave_t wave_cosine,
  output logic                prod_valid,
  output lockin_pkg::prod_t   prod_i,         // sample x sine
  output lockin_pkg::prod_t   prod_q,         // sample x cosine
  output logic                prod_bank,      // bank the product belongs to
  output logic                prod_frame_end, // close prod_end_bank
  output logic                prod_end_bank
);

  import lockin_pkg::*;

  sample_t s1_sample;   // sample held for the table latency
  logic    s1_valid;
  logic    s1_bank;
  logic    s1_end;
  logic    s1_end_bank;

  ////////////////////////////////////////////////////////////
  // stage 1, wait for the table
  ////////////////////////////////////////////////////////////

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      s1_valid <= 1'b0;
      s1_end   <= 1'b0;
    end
    else
    begin
      s1_valid <= frm.sample_stb;
      s1_end   <= frm.frame_end;
    end
  end

  always_ff @(posedge alg_clk)
  begin
    s1_sample   <= frm.ref_sample;
    s1_bank     <= frm.frame_end ? ~frm.bank : frm.bank;  // boundary sample opens new frame
    s1_end_bank <= frm.bank;                              // bank being closed
  end

  ////////////////////////////////////////////////////////////
  // stage 2, signed products
  ////////////////////////////////////////////////////////////

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      prod_valid     <= 1'b0;
      prod_frame_end <= 1'b0;
    end
    else
    begin
      prod_valid     <= s1_valid;
      prod_frame_end <= s1_end;   // same depth as data, lands after last product
    end
  end

  always_ff @(posedge alg_clk)
  begin
    prod_i        <= prod_t'(s1_sample) * prod_t'(wave_sine);
    prod_q        <= prod_t'(s1_sample) * prod_t'(wave_cosine);
    prod_bank     <= s1_bank;
    prod_end_bank <= s1_end_bank;
  end

endmodule

`default_nettype wire

// ==== rtl/lockin_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module lockin_top (
  input  wire                       alg_clk,
  input  wire                       alg_rst_n,
  input  wire                       search_end,
  input  wire                       pem_posedge,
  input  wire lockin_pkg::sample_t  ref_dat,
  input  wire                       ref_dat_valid,
  input  wire lockin_pkg::wave_t    wave_sine,
  input  wire lockin_pkg::wave_t    wave_cosine,
  output wire                       wave_req,
  output wire lockin_pkg::wave_addr_t wave_addr,
  output wire                       buf_refresh,
  output wire lockin_pkg::acc_t     i_sum,
  output wire lockin_pkg::acc_t     q_sum,
  output wire                       sum_valid
);

  import lockin_pkg::*;

  ////////////////////////////////////////////////////////////
  // mixer to accumulator
  ////////////////////////////////////////////////////////////

  logic  prod_valid;
  prod_t prod_i;
  prod_t prod_q;
  logic  prod_bank;
  logic  prod_frame_end;
  logic  prod_end_bank;

  frame_if frm_if ();   // sequencer tags

  pem_frame_seq u_seq (
    .alg_clk       (alg_clk),
    .alg_rst_n     (alg_rst_n),
    .search_end    (search_end),
    .pem_posedge   (pem_posedge),
    .ref_dat       (ref_dat),
    .ref_dat_valid (ref_dat_valid),
    .wave_req      (wave_req),
    .wave_addr     (wave_addr),
    .buf_refresh   (buf_refresh),
    .frm           (frm_if.seq)
  );

  lockin_mixer u_mixer (
    .alg_clk        (alg_clk),
    .alg_rst_n      (alg_rst_n),
    .frm            (frm_if.demod),
    .wave_sine      (wave_sine),      // table reply, one cycle after wave_req
    .wave_cosine    (wave_cosine),
    .prod_valid     (prod_valid),
    .prod_i         (prod_i),
    .prod_q         (prod_q),
    .prod_bank      (prod_bank),
    .prod_frame_end (prod_frame_end),
    .prod_end_bank  (prod_end_bank)
  );

  frame_accum u_accum (
    .alg_clk        (alg_clk),
    .alg_rst_n      (alg_rst_n),
    .prod_valid     (prod_valid),
    .prod_i         (prod_i),
    .prod_q         (prod_q),
    .prod_bank      (prod_bank),
    .prod_frame_end (prod_frame_end),
    .prod_end_bank  (prod_end_bank),
    .i_sum          (i_sum),
    .q_sum          (q_sum),
    .sum_valid      (sum_valid)
  );

endmodule

`default_nettype wire

// ==== rtl/pem_frame_seq.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lockin_config.svh"

module pem_frame_seq (
  input  wire                    alg_clk,
  input  wire                    alg_rst_n,
  input  wire                    search_end,     // phase search done, arm sync
  input  wire                    pem_posedge,    // one cycle pulse per pem period
  input  wire lockin_pkg::sample_t ref_dat,
  input  wire                    ref_dat_valid,
  output logic                   wave_req,       // table read strobe
  output lockin_pkg::wave_addr_t wave_addr,      // table index
  output logic                   buf_refresh,    // frame boundary, combinational
  frame_if.seq                   frm
);

  import lockin_pkg::*;

  seq_state_t  state;
  seq_state_t  state_nxt;
  period_cnt_t period_cnt;  // pem period within frame
  wave_addr_t  addr_r;      // next table index
  logic        bank_r;      // ping/pong select
  logic        synced;
  logic        boundary;

  ////////////////////////////////////////////////////////////
  // arming and pem sync
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    state_nxt = state;
    case (state)
      SEQ_IDLE:   if (search_end)  state_nxt = SEQ_ARMED;
      SEQ_ARMED:  if (pem_posedge) state_nxt = SEQ_SYNCED;  // first frame starts here
      SEQ_SYNCED: state_nxt = SEQ_SYNCED;                   // stays locked until reset
      default:    state_nxt = SEQ_IDLE;
    endcase
  end

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
      state <= SEQ_IDLE;
    else
      state <= state_nxt;
  end

  assign synced   = (state == SEQ_SYNCED);
  // fifth edge after sync closes the frame
  assign boundary = synced && pem_posedge &&
                    (period_cnt == period_cnt_t'(`LOCKIN_FRAME_PERIODS - 1));

  ////////////////////////////////////////////////////////////
  // period counter and bank flag
  ////////////////////////////////////////////////////////////

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
    begin
      period_cnt <= '0;
      bank_r     <= 1'b0;
    end
    else
    begin
      if (state == SEQ_ARMED && pem_posedge)
        period_cnt <= '0;                          // sync edge is period 0
      else if (boundary)
        period_cnt <= '0;
      else if (synced && pem_posedge)
        period_cnt <= period_cnt + period_cnt_t'(1);
      if (boundary)
        bank_r <= ~bank_r;                         // flips after boundary cycle
    end
  end

  ////////////////////////////////////////////////////////////
  // wave table addressing
  ////////////////////////////////////////////////////////////

  assign wave_req  = synced && ref_dat_valid;
  assign wave_addr = (wave_req && boundary) ? '0 : addr_r;  // boundary request opens frame

  always_ff @(posedge alg_clk or negedge alg_rst_n)
  begin
    if (!alg_rst_n)
      addr_r <= '0;
    else if (boundary)
      addr_r <= wave_req ? wave_addr_t'(1) : '0;   // index 0 already used if req
    else if (wave_req)
      addr_r <= addr_r + wave_addr_t'(1);          // wraps at table end
  end

  assign buf_refresh = boundary;

  // tags toward the demodulator
  assign frm.sample_stb = wave_req;
  assign frm.frame_end  = boundary;
  assign frm.bank       = bank_r;   // still the closing frame's bank at boundary
  assign frm.ref_sample = ref_dat;

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the lock-in testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f build.f --top-module lockin_tb

status=0
./obj_dir/Vlockin_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TESTS FAILED" sim.log; then
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
exit 0

// ==== verif/lockin_chk.sv ====
`timescale 1ns/10ps
`default_nettype none

module lockin_chk (
  input wire                         alg_clk,
  input wire                         alg_rst_n,
  input wire                         wave_req,
  input wire                         buf_refresh,
  input wire                         sum_valid
);

  ////////////////////////////////////////////////////////////
  // control outputs
  ////////////////////////////////////////////////////////////

  reset_quiet: assert property (@(posedge alg_clk)
    !alg_rst_n |-> (!wave_req && !buf_refresh && !sum_valid))   // nothing leaks in reset
    else $error("control output active while in reset");

  sum_latency: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    sum_valid == $past(buf_refresh, 3))                   // boundary to strobe, both ways
    else $error("sum_valid not three cycles after buf_refresh");

  single_refresh: assert property (@(posedge alg_clk) disable iff (!alg_rst_n)
    buf_refresh |=> !buf_refresh)                         // counter restarts at boundary
    else $error("buf_refresh high for two cycles");

endmodule

bind lockin_top lockin_chk u_chk (
  .alg_clk     (alg_clk),
  .alg_rst_n   (alg_rst_n),
  .wave_req    (wave_req),
  .buf_refresh (buf_refresh),
  .sum_valid   (sum_valid)
);

`default_nettype wire

// ==== verif/lockin_scoreboard.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "lockin_config.svh"

module lockin_scoreboard (
  input  wire                         alg_clk,
  input  wire                         alg_rst_n,
  input  wire                         search_end,
  input  wire                         pem_posedge,
  input  wire lockin_pkg::sample_t    ref_dat,
  input  wire                         ref_dat_valid,
  input  wire lockin_pkg::wave_t      wave_sine,
  input  wire lockin_pkg::wave_t      wave_cosine,
  input  wire                         wave_req,
  input  wire lockin_pkg::wave_addr_t wave_addr,
  input  wire                         buf_refresh,
  input  wire lockin_pkg::acc_t       i_sum,
  input  wire lockin_pkg::acc_t       q_sum,
  input  wire                         sum_valid,
  output int                          value_errs,
  output int                          ctrl_errs,
  output int                          frames_checked,
  output int                          sums_pending
);

  import lockin_pkg::*;

  seq_state_t st;            // model of the sequencer
  int         cnt;           // pem period in frame
  wave_addr_t addr;          // next table index
  logic       pend;          // request last cycle, table data now
  sample_t    pend_sample;
  longint     cur_i;         // running sums of the open frame
  longint     cur_q;
  int         cyc = 0;
  int         n_val = 0;
  int         n_ctrl = 0;
  int         n_frames = 0;
  int         n_pend = 0;
  int         exp_cyc [$];   // strobe cycle per closed frame
  longint     exp_i [$];
  longint     exp_q [$];
  logic       exp_req;
  logic       exp_bnd;
  wave_addr_t exp_addr;
  acc_t       e_i;
  acc_t       e_q;

  assign value_errs     = n_val;
  assign ctrl_errs      = n_ctrl;
  assign frames_checked = n_frames;
  assign sums_pending   = n_pend;

  task automatic compare_ctrl(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
    if (got !== exp)
    begin
      $display("Error: %s = 0x%h, expected 0x%h at %0t", name, got, exp, $time);
      n_ctrl++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // compare at the falling edge, everything settled
  ////////////////////////////////////////////////////////////

  always @(negedge alg_clk)
  begin
    cyc++;
    if (!alg_rst_n)
    begin
      compare_ctrl("wave_req", 16'(wave_req), 16'h0);         // quiet in reset
      compare_ctrl("buf_refresh", 16'(buf_refresh), 16'h0);
      compare_ctrl("sum_valid", 16'(sum_valid), 16'h0);
      st    = SEQ_IDLE;
      cnt   = 0;
      addr  = '0;
      pend  = 1'b0;
      cur_i = 0;
      cur_q = 0;
    end
    else
    begin
      exp_req  = (st == SEQ_SYNCED) && ref_dat_valid;
      exp_bnd  = (st == SEQ_SYNCED) && pem_posedge && (cnt == `LOCKIN_FRAME_PERIODS - 1);
      exp_addr = (exp_req && exp_bnd) ? '0 : addr;
      compare_ctrl("wave_req", 16'(wave_req), 16'(exp_req));
      compare_ctrl("buf_refresh", 16'(buf_refresh), 16'(exp_bnd));
      if (exp_req)
        compare_ctrl("wave_addr", 16'(wave_addr), 16'(exp_addr));
      if (pend)   // table reply for last cycle's request
      begin
        cur_i += longint'(pend_sample) * longint'(wave_sine);
        cur_q += longint'(pend_sample) * longint'(wave_cosine);
      end
      if (exp_bnd)   // close frame, boundary request goes to the next one
      begin
        exp_cyc.push_back(cyc + `LOCKIN_SUM_LAT);
        exp_i.push_back(cur_i);
        exp_q.push_back(cur_q);
        cur_i = 0;
        cur_q = 0;
      end
      pend        = exp_req;
      pend_sample = ref_dat;
      if (sum_valid)
      begin
        if (exp_cyc.size() == 0 || exp_cyc[0] != cyc)
        begin
          $display("sum_valid pulsed with no frame boundary three cycles before, %0t", $time);
          n_ctrl++;
        end
        else
        begin
          e_i = acc_t'(exp_i[0]);   // 40 bit frame sum
          e_q = acc_t'(exp_q[0]);
          if (i_sum !== e_i)
          begin
            $display("Error: i_sum = 0x%h, expected 0x%h at %0t", i_sum, e_i, $time);
            n_val++;
          end
          if (q_sum !== e_q)
          begin
            $display("Error: q_sum = 0x%h, expected 0x%h at %0t", q_sum, e_q, $time);
            n_val++;
          end
          n_frames++;
          void'(exp_cyc.pop_front());
          void'(exp_i.pop_front());
          void'(exp_q.pop_front());
        end
      end
      else if (exp_cyc.size() != 0 && exp_cyc[0] == cyc)
      begin
        $display("sum_valid missing three cycles after a frame boundary, %0t", $time);
        n_ctrl++;
        void'(exp_cyc.pop_front());
        void'(exp_i.pop_front());
        void'(exp_q.pop_front());
      end
      case (st)   // advance as the coming rising edge will
        SEQ_IDLE:  if (search_end) st = SEQ_ARMED;
        SEQ_ARMED:
          if (pem_posedge)
          begin
            st  = SEQ_SYNCED;
            cnt = 0;
          end
        default:   if (pem_posedge) cnt = exp_bnd ? 0 : cnt + 1;
      endcase
      if (exp_bnd)
        addr = exp_req ? wave_addr_t'(1) : '0;
      else if (exp_req)
        addr = addr + wave_addr_t'(1);
    end
    n_pend = exp_cyc.size();
  end

endmodule

`default_nettype wire

// ==== verif/lockin_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module lockin_tb;

  import lockin_pkg::*;

  logic       alg_clk;
  logic       alg_rst_n;
  logic       search_end;
  logic       pem_posedge;
  sample_t    ref_dat;
  logic       ref_dat_valid;
  wave_t      wave_sine = '0;     // table model output
  wave_t      wave_cosine = '0;
  logic       wave_req;
  wave_addr_t wave_addr;
  logic       buf_refresh;
  acc_t       i_sum;
  acc_t       q_sum;
  logic       sum_valid;
  int         value_errs;
  int         ctrl_errs;
  int         frames_checked;
  int         sums_pending;
  int         run_errs;
  logic       drained;
  integer     seed = 32'h2046;
  wave_t      sin_tab [512];      // random wave table
  wave_t      cos_tab [512];

  initial
  begin
    alg_clk = 1'b0;
    forever #2 alg_clk = ~alg_clk;   // 4 ns
  end

  // table answers one cycle after the request
  always @(posedge alg_clk)
  begin
    if (wave_req)
    begin
      wave_sine   <= sin_tab[wave_addr];
      wave_cosine <= cos_tab[wave_addr];
    end
    else
    begin
      wave_sine   <= 16'sh5a5a;   // junk, never summed
      wave_cosine <= 16'sha5a5;
    end
  end

  lockin_top UUT (
    .alg_clk       (alg_clk),
    .alg_rst_n     (alg_rst_n),
    .search_end    (search_end),
    .pem_posedge   (pem_posedge),
    .ref_dat       (ref_dat),
    .ref_dat_valid (ref_dat_valid),
    .wave_sine     (wave_sine),
    .wave_cosine   (wave_cosine),
    .wave_req      (wave_req),
    .wave_addr     (wave_addr),
    .buf_refresh   (buf_refresh),
    .i_sum         (i_sum),
    .q_sum         (q_sum),
    .sum_valid     (sum_valid)
  );

  lockin_scoreboard u_sb (.*);

  task automatic drive_cycle(input logic pem);
    @(posedge alg_clk);
    pem_posedge   <= pem;
    ref_dat_valid <= (($random(seed) & 3) != 0);   // about 3 in 4 cycles
    ref_dat       <= sample_t'($random(seed));
  endtask

  task automatic run_pem_periods(input int n, input int gap_min, input int gap_max);
    int gap;
    for (int p = 0; p < n; p++)
    begin
      gap = gap_min + int'($unsigned($random(seed)) % (gap_max - gap_min + 1));
      drive_cycle(1'b1);
      for (int c = 1; c < gap; c++)
        drive_cycle(1'b0);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial
  begin
    alg_rst_n     = 1'b0;
    search_end    = 1'b0;
    pem_posedge   = 1'b0;
    ref_dat       = '0;
    ref_dat_valid = 1'b0;
    run_errs      = 0;
    drained       = 1'b0;
    for (int a = 0; a < 512; a++)
    begin
      sin_tab[a] = wave_t'($random(seed));
      cos_tab[a] = wave_t'($random(seed));
    end
    repeat (5) @(posedge alg_clk);
    alg_rst_n <= 1'b1;
    run_pem_periods(6, 20, 40);   // not armed, outputs stay quiet
    drive_cycle(1'b0);
    search_end <= 1'b1;           // arm, next pem edge syncs
    drive_cycle(1'b0);
    search_end <= 1'b0;
    run_pem_periods(60, 20, 60);  // sync edge, then long frames
    run_pem_periods(40, 1, 4);    // short frames, both banks busy
    for (int w = 0; w < 64 && !drained; w++)
    begin
      drive_cycle(1'b0);
      drained = (sums_pending == 0);
    end
    if (!drained)
    begin
      $display("timed out waiting for the last frame sums");
      run_errs++;
    end
    repeat (8) drive_cycle(1'b0);   // room for a stray sum_valid
    if (frames_checked < 15)
    begin
      $display("only %0d frame sums were checked", frames_checked);
      run_errs++;
    end
    $display("value errors %0d, control errors %0d, run errors %0d, frames checked %0d",
             value_errs, ctrl_errs, run_errs, frames_checked);
    if (value_errs == 0 && ctrl_errs == 0 && run_errs == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire
